/* cdc_burst_bridge.f */
+incdir+src
src/cdc_burst_pkg.sv
src/cdc_burst_if.sv
src/dualport_ram.sv
src/gray_ptr_sync.sv
src/async_fifo.sv
src/drain_timer.sv
src/burst_reader_fsm.sv
src/cdc_burst_bridge.sv
test/cdc_burst_bridge_properties.sv
test/cdc_burst_bridge_tb.sv

/* Bender.yml */
package:
  name: cdc_burst_bridge

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/cdc_burst_pkg.sv
      - src/cdc_burst_if.sv
      - src/dualport_ram.sv
      - src/gray_ptr_sync.sv
      - src/async_fifo.sv
      - src/drain_timer.sv
      - src/burst_reader_fsm.sv
      - src/cdc_burst_bridge.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/cdc_burst_bridge_properties.sv
      - test/cdc_burst_bridge_tb.sv

/* test/cdc_burst_bridge_tb.sv */
`timescale 1ns/10ps
`include "cdc_burst_macros.svh"

module cdc_burst_bridge_tb;

  localparam real WR_PERIOD = 8.0;
  localparam real RD_PERIOD = 11.0;
  localparam int  NUM_ROWS = 9;
  localparam int  SETTLE_CYCLES = 48;
  localparam logic [31:0] SEED = 32'h1102_7d9b;

  typedef struct {
    int words;
    bit hold;
    int exp_accepted;
    int exp_bursts;
  } row_t;

  // The last two rows fill the FIFO under hold and then release it.
  row_t rows [NUM_ROWS] = '{
    '{words: 0,  hold: 1'b0, exp_accepted: 0,  exp_bursts: 0},
    '{words: 4,  hold: 1'b0, exp_accepted: 4,  exp_bursts: 1},
    '{words: 8,  hold: 1'b0, exp_accepted: 8,  exp_bursts: 2},
    '{words: 12, hold: 1'b0, exp_accepted: 12, exp_bursts: 3},
    '{words: 3,  hold: 1'b0, exp_accepted: 3,  exp_bursts: 1},
    '{words: 6,  hold: 1'b0, exp_accepted: 6,  exp_bursts: 2},
    '{words: 1,  hold: 1'b0, exp_accepted: 1,  exp_bursts: 1},
    '{words: 20, hold: 1'b1, exp_accepted: 16, exp_bursts: 0},
    '{words: 0,  hold: 1'b0, exp_accepted: 0,  exp_bursts: 4}
  };

  logic                  wr_clk;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  wr_en;
  cdc_burst_pkg::data_t  wr_data;
  logic                  full;
  logic                  afull;
  logic                  hold;
  logic                  out_valid;
  cdc_burst_pkg::data_t  out_data;
  logic                  out_last;

  cdc_burst_pkg::data_t  ref_q[$];
  int                    burst_lens[$];
  int                    exp_lens[$];
  int                    beat_cnt = 0;
  int                    errors = 0;
  logic [31:0]           rng_state;

  cdc_burst_bridge dut_i (
    .wr_clk    (wr_clk),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .wr_en     (wr_en),
    .wr_data   (wr_data),
    .full      (full),
    .afull     (afull),
    .hold      (hold),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_last  (out_last)
  );

  initial begin
    wr_clk = 1'b0;
    forever #(WR_PERIOD / 2.0) wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #(RD_PERIOD / 2.0) rd_clk = ~rd_clk;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic flag_error(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  // Full bursts first, then one drained burst for the remainder.
  task automatic split_into_bursts(input int total);
    int left;
    left = total;
    exp_lens.delete();
    while (left >= `CDC_BURST_LEN) begin
      exp_lens.push_back(`CDC_BURST_LEN);
      left -= `CDC_BURST_LEN;
    end
    if (left > 0) begin
      exp_lens.push_back(left);
    end
  endtask

  // A word counts as accepted when full is low at the edge that takes it.
  task automatic write_words(input int count, input bit check_flags, output int accepted);
    cdc_burst_pkg::data_t word;
    accepted = 0;
    for (int i = 0; i < count; i++) begin
      @(posedge wr_clk);
      rng_state = xorshift32(rng_state);
      word = rng_state[`CDC_DATA_WIDTH-1:0];
      wr_en <= 1'b1;
      wr_data <= word;
      @(negedge wr_clk);
      if (check_flags && afull !== (accepted >= `CDC_AFULL_LEVEL)) begin
        flag_error($sformatf("afull is %b with %0d words held", afull, accepted));
      end
      if (check_flags && full !== (accepted >= `CDC_FIFO_DEPTH)) begin
        flag_error($sformatf("full is %b with %0d words held", full, accepted));
      end
      if (full === 1'b0) begin
        ref_q.push_back(word);
        accepted++;
      end
    end
    @(posedge wr_clk);
    wr_en <= 1'b0;
    @(negedge wr_clk);
    if (check_flags && (afull !== 1'b1 || full !== 1'b1)) begin
      flag_error($sformatf("flags afull=%b full=%b after %0d words", afull, full, accepted));
    end
  endtask

  // --------------------------------------------------
  // Output monitor
  // --------------------------------------------------
  initial begin : output_monitor
    cdc_burst_pkg::data_t expected;
    forever begin
      @(negedge rd_clk);
      if (out_last === 1'b1 && out_valid !== 1'b1) begin
        flag_error("out_last without out_valid");
      end
      if (out_valid === 1'b1) begin
        beat_cnt++;
        if (ref_q.size() == 0) begin
          flag_error($sformatf("unexpected word %h", out_data));
        end else begin
          expected = ref_q.pop_front();
          if (out_data !== expected) begin
            flag_error($sformatf("out_data %h, expected %h", out_data, expected));
          end
        end
        if (out_last === 1'b1) begin
          burst_lens.push_back(beat_cnt);
          beat_cnt = 0;
        end else if (beat_cnt >= `CDC_BURST_LEN) begin
          flag_error($sformatf("burst of %0d words without out_last", beat_cnt));
        end
      end
    end
  end

  initial begin : watchdog
    real limit;
    int  total_words;
    total_words = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total_words += rows[r].words;
    end
    limit = total_words * 40 * RD_PERIOD + NUM_ROWS * SETTLE_CYCLES * WR_PERIOD * 4.0;
    #(limit);
    $display("Watchdog expired after %0t, the run did not finish in time", $time);
    $display("tests failed");
    $finish;
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : main_sequence
    int accepted;
    int held;
    int errs_before;
    int passed;
    int assert_fails;
    rd_rst_n = 1'b0;
    wr_en = 1'b0;
    wr_data = '0;
    hold = 1'b0;
    rng_state = SEED;
    held = 0;
    passed = 0;
    repeat (2) @(posedge wr_clk);
    rd_rst_n <= 1'b1;
    @(negedge wr_clk);
    errs_before = errors;
    if (full !== 1'b0 || afull !== 1'b0 || dut_i.rd_bus.empty !== 1'b1) begin
      flag_error("FIFO flags wrong after reset");
    end
    if (out_valid !== 1'b0 || out_last !== 1'b0) begin
      flag_error("output active after reset");
    end
    passed += (errors == errs_before);
    $display("reset: %s", (errors == errs_before) ? "pass" : "fail");

    for (int r = 0; r < NUM_ROWS; r++) begin
      errs_before = errors;
      burst_lens.delete();
      @(posedge wr_clk);
      hold <= rows[r].hold;
      write_words(rows[r].words, rows[r].hold, accepted);
      if (rows[r].hold) begin
        held += accepted;
        split_into_bursts(0);
      end else begin
        split_into_bursts(held + accepted);
        held = 0;
        while (ref_q.size() != 0 || beat_cnt != 0) begin
          @(posedge wr_clk);
        end
      end
      repeat (SETTLE_CYCLES) @(posedge wr_clk);
      @(negedge wr_clk);
      if (accepted != rows[r].exp_accepted) begin
        flag_error($sformatf("%0d words accepted, expected %0d", accepted,
                             rows[r].exp_accepted));
      end
      if (burst_lens.size() != rows[r].exp_bursts) begin
        flag_error($sformatf("%0d bursts, expected %0d", burst_lens.size(),
                             rows[r].exp_bursts));
      end
      if (burst_lens.size() != exp_lens.size()) begin
        flag_error($sformatf("burst count %0d, rule gives %0d", burst_lens.size(),
                             exp_lens.size()));
      end else begin
        for (int b = 0; b < exp_lens.size(); b++) begin
          if (burst_lens[b] != exp_lens[b]) begin
            flag_error($sformatf("burst %0d has %0d words, expected %0d", b,
                                 burst_lens[b], exp_lens[b]));
          end
        end
      end
      if (rows[r].hold && (full !== 1'b1 || afull !== 1'b1)) begin
        flag_error($sformatf("held FIFO shows full=%b afull=%b", full, afull));
      end
      if (!rows[r].hold && (full !== 1'b0 || afull !== 1'b0)) begin
        flag_error($sformatf("drained FIFO shows full=%b afull=%b", full, afull));
      end
      passed += (errors == errs_before);
      $display("row %0d: words %0d hold %0b accepted %0d bursts %0d: %s", r, rows[r].words,
               rows[r].hold, accepted, burst_lens.size(),
               (errors == errs_before) ? "pass" : "fail");
    end

    assert_fails = dut_i.fifo_i.fifo_props_i.fail_count
                   + dut_i.reader_i.reader_props_i.fail_count;
    if (assert_fails != 0) begin
      $display("%0d assertion failures were reported by the bound checkers", assert_fails);
      errors += assert_fails;
    end

    $display("summary: %0d tests, %0d passed, %0d errors", NUM_ROWS + 1, passed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* test/cdc_burst_bridge_properties.sv */
`timescale 1ns/10ps
`include "cdc_burst_macros.svh"

module cdc_burst_bridge_properties (
  input logic                 wr_clk,
  input logic                 rd_clk,
  input logic                 rd_rst_n,
  input logic                 wr_accept,
  input cdc_burst_pkg::ptr_t  wr_level,
  input logic                 full,
  input logic                 rd_issue,
  input cdc_burst_pkg::ptr_t  rd_level,
  input logic                 empty,
  input logic                 out_valid,
  input logic                 out_last
);

  int fail_count = 0;

  // --------------------------------------------------
  // FIFO flags
  // --------------------------------------------------
  // An accepted write must find a free entry in the level the write side sees.
  write_while_full_a : assert property (
    @(posedge wr_clk) disable iff (!rd_rst_n)
      wr_accept |-> (wr_level < `CDC_FIFO_DEPTH)
  ) else begin
    fail_count++;
    $error("write accepted while the FIFO is full");
  end

  read_while_empty_a : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) rd_issue |-> (rd_level != '0)
  ) else begin
    fail_count++;
    $error("read issued while the FIFO is empty");
  end

  full_and_empty_a : assert property (
    @(posedge wr_clk) disable iff (!rd_rst_n) !(full && empty)
  ) else begin
    fail_count++;
    $error("full and empty are high together");
  end

  // --------------------------------------------------
  // Output framing
  // --------------------------------------------------
  // A burst runs on consecutive cycles up to the beat that carries out_last.
  burst_gap_a : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) (out_valid && !out_last) |=> out_valid
  ) else begin
    fail_count++;
    $error("burst interrupted before out_last");
  end

endmodule

// The FIFO instance checks the flags, the reader instance the framing.
bind async_fifo cdc_burst_bridge_properties fifo_props_i (
  .wr_clk    (wr_clk),
  .rd_clk    (rd_clk),
  .rd_rst_n  (rd_rst_n),
  .wr_accept (ram.wr_en),
  .wr_level  (wr_bin - rd_bin_wsync),
  .full      (full),
  .rd_issue  (ram.rd_en),
  .rd_level  (rd.rd_level),
  .empty     (rd.empty),
  .out_valid (1'b0),
  .out_last  (1'b0)
);

bind burst_reader_fsm cdc_burst_bridge_properties reader_props_i (
  .wr_clk    (rd_clk),
  .rd_clk    (rd_clk),
  .rd_rst_n  (rd_rst_n),
  .wr_accept (1'b0),
  .wr_level  ('0),
  .full      (1'b0),
  .rd_issue  (fifo.rd_en),
  .rd_level  (fifo.rd_level),
  .empty     (fifo.empty),
  .out_valid (out_valid),
  .out_last  (out_last)
);

/* src/cdc_burst_bridge.sv */
`timescale 1ns/10ps

module cdc_burst_bridge (
  input  logic                  wr_clk,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  wr_en,
  input  cdc_burst_pkg::data_t  wr_data,
  output logic                  full,
  output logic                  afull,
  input  logic                  hold,
  output logic                  out_valid,
  output cdc_burst_pkg::data_t  out_data,
  output logic                  out_last
);

  logic timer_run;
  logic timer_expired;

  ram_port_if ram_bus ();
  fifo_rd_if  rd_bus ();

  async_fifo fifo_i (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .afull    (afull),
    .ram      (ram_bus.ctrl),
    .rd       (rd_bus.fifo)
  );

  dualport_ram ram_i (
    .wr_clk (wr_clk),
    .rd_clk (rd_clk),
    .port   (ram_bus.mem)
  );

  drain_timer timer_i (
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .run      (timer_run),
    .expired  (timer_expired)
  );

  burst_reader_fsm reader_i (
    .rd_clk        (rd_clk),
    .rd_rst_n      (rd_rst_n),
    .hold          (hold),
    .fifo          (rd_bus.reader),
    .timer_run     (timer_run),
    .timer_expired (timer_expired),
    .out_valid     (out_valid),
    .out_data      (out_data),
    .out_last      (out_last)
  );

endmodule

/* src/burst_reader_fsm.sv */
`timescale 1ns/10ps
`include "cdc_burst_macros.svh"

module burst_reader_fsm (
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  hold,
  fifo_rd_if.reader             fifo,
  output logic                  timer_run,
  input  logic                  timer_expired,
  output logic                  out_valid,
  output cdc_burst_pkg::data_t  out_data,
  output logic                  out_last
);

  cdc_burst_pkg::rd_state_e  state;
  cdc_burst_pkg::rd_state_e  state_nxt;
  cdc_burst_pkg::ptr_t       remain;
  logic                      active;
  logic                      partial;
  logic                      final_beat;

  assign partial = (fifo.rd_level != '0) && (fifo.rd_level < `CDC_BURST_LEN);
  assign active  = (state != cdc_burst_pkg::RD_IDLE);

  // The timer only runs while a short burst waits and nothing else
  // is going on.
  assign timer_run = (state == cdc_burst_pkg::RD_IDLE) && !hold && partial;

  assign fifo.rd_en = active && !fifo.empty;
  assign final_beat = fifo.rd_en && (remain == cdc_burst_pkg::ptr_t'(1));

  always_comb begin
    state_nxt = state;
    case (state)
      cdc_burst_pkg::RD_IDLE: begin
        if (!hold) begin
          if (fifo.rd_level >= `CDC_BURST_LEN) begin
            state_nxt = cdc_burst_pkg::RD_BURST;
          end else if (timer_expired) begin
            state_nxt = cdc_burst_pkg::RD_DRAIN;
          end
        end
      end
      cdc_burst_pkg::RD_BURST,
      cdc_burst_pkg::RD_DRAIN: begin
        if (final_beat) begin
          state_nxt = cdc_burst_pkg::RD_IDLE;
        end
      end
      default: state_nxt = cdc_burst_pkg::RD_IDLE;
    endcase
  end

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      state  <= cdc_burst_pkg::RD_IDLE;
      remain <= '0;
    end else begin
      state <= state_nxt;
      if (!active) begin
        // A drain reads only what was waiting when the timer fired.
        if (state_nxt == cdc_burst_pkg::RD_BURST) begin
          remain <= cdc_burst_pkg::ptr_t'(`CDC_BURST_LEN);
        end else if (state_nxt == cdc_burst_pkg::RD_DRAIN) begin
          remain <= fifo.rd_level;
        end
      end else if (fifo.rd_en) begin
        remain <= remain - 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Output stage, one cycle behind the read.
  // --------------------------------------------------
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      out_valid <= 1'b0;
      out_last  <= 1'b0;
    end else begin
      out_valid <= fifo.rd_en;
      out_last  <= final_beat;
    end
  end

  // RAM read data is registered and lines up with out_valid.
  assign out_data = fifo.rd_data;

endmodule

/* src/drain_timer.sv */
`timescale 1ns/10ps
`include "cdc_burst_macros.svh"

module drain_timer (
  input  logic  rd_clk,
  input  logic  rd_rst_n,
  input  logic  run,
  output logic  expired
);

  logic [$clog2(`CDC_DRAIN_TIMEOUT+1)-1:0] count;
  logic                                    at_limit;

  assign at_limit = (count == `CDC_DRAIN_TIMEOUT);

  // Counts consecutive run cycles and saturates at the timeout.
  // Any cycle with run low starts the count over.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      count <= '0;
    end else if (!run) begin
      count <= '0;
    end else if (!at_limit) begin
      count <= count + 1'b1;
    end
  end

  // Drops in the same cycle that run falls.
  assign expired = run && at_limit;

endmodule

/* src/async_fifo.sv */
`timescale 1ns/10ps
`include "cdc_burst_macros.svh"

module async_fifo (
  input  logic                  wr_clk,
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  wr_en,
  input  cdc_burst_pkg::data_t  wr_data,
  output logic                  full,
  output logic                  afull,
  ram_port_if.ctrl              ram,
  fifo_rd_if.fifo               rd
);

  logic                 wr_ok;
  cdc_burst_pkg::ptr_t  wr_bin;
  cdc_burst_pkg::ptr_t  wr_bin_nxt;
  cdc_burst_pkg::ptr_t  wr_gray;
  cdc_burst_pkg::ptr_t  wr_gray_nxt;
  cdc_burst_pkg::ptr_t  wr_level_nxt;
  cdc_burst_pkg::ptr_t  rd_gray_wsync;
  cdc_burst_pkg::ptr_t  rd_bin_wsync;
  cdc_burst_pkg::ptr_t  full_gray;

  logic                 rd_ok;
  cdc_burst_pkg::ptr_t  rd_bin;
  cdc_burst_pkg::ptr_t  rd_bin_nxt;
  cdc_burst_pkg::ptr_t  rd_gray;
  cdc_burst_pkg::ptr_t  rd_gray_nxt;
  cdc_burst_pkg::ptr_t  wr_gray_rsync;
  cdc_burst_pkg::ptr_t  wr_bin_rsync;

  // --------------------------------------------------
  // Write domain
  // --------------------------------------------------
  assign wr_ok       = wr_en && !full;
  assign wr_bin_nxt  = wr_bin + cdc_burst_pkg::ptr_t'(wr_ok);
  assign wr_gray_nxt = (wr_bin_nxt >> 1) ^ wr_bin_nxt;

  // The FIFO is full when the write pointer is one lap ahead of the
  // read pointer. In Gray code that means the two top bits differ.
  assign full_gray = {~rd_gray_wsync[`CDC_ADDR_WIDTH -: 2],
                      rd_gray_wsync[`CDC_ADDR_WIDTH-2:0]};

  assign wr_level_nxt = wr_bin_nxt - rd_bin_wsync;

  always_ff @(posedge wr_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;
      full    <= (wr_gray_nxt == full_gray);
      afull   <= (wr_level_nxt >= `CDC_AFULL_LEVEL);
    end
  end

  gray_ptr_sync #(
    .PTR_WIDTH ($bits(cdc_burst_pkg::ptr_t))
  ) rd_ptr_sync_i (
    .dst_clk  (wr_clk),
    .rd_rst_n (rd_rst_n),
    .gray_in  (rd_gray),
    .gray_out (rd_gray_wsync),
    .bin_out  (rd_bin_wsync)
  );

  // --------------------------------------------------
  // Read domain
  // --------------------------------------------------
  assign rd_ok       = rd.rd_en && !rd.empty;
  assign rd_bin_nxt  = rd_bin + cdc_burst_pkg::ptr_t'(rd_ok);
  assign rd_gray_nxt = (rd_bin_nxt >> 1) ^ rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin   <= '0;
      rd_gray  <= '0;
      rd.empty <= 1'b1;
    end else begin
      rd_bin   <= rd_bin_nxt;
      rd_gray  <= rd_gray_nxt;
      rd.empty <= (rd_gray_nxt == wr_gray_rsync);
    end
  end

  gray_ptr_sync #(
    .PTR_WIDTH ($bits(cdc_burst_pkg::ptr_t))
  ) wr_ptr_sync_i (
    .dst_clk  (rd_clk),
    .rd_rst_n (rd_rst_n),
    .gray_in  (wr_gray),
    .gray_out (wr_gray_rsync),
    .bin_out  (wr_bin_rsync)
  );

  // Level as seen from the read side, may lag the real one.
  assign rd.rd_level = wr_bin_rsync - rd_bin;

  // Memory port.
  assign ram.wr_en   = wr_ok;
  assign ram.wr_addr = wr_bin[`CDC_ADDR_WIDTH-1:0];
  assign ram.wr_data = wr_data;
  assign ram.rd_en   = rd_ok;
  assign ram.rd_addr = rd_bin[`CDC_ADDR_WIDTH-1:0];
  assign rd.rd_data  = ram.rd_data;

endmodule

/* src/gray_ptr_sync.sv */
`timescale 1ns/10ps

module gray_ptr_sync #(
  parameter int PTR_WIDTH = $bits(cdc_burst_pkg::ptr_t)
) (
  input  logic                 dst_clk,
  input  logic                 rd_rst_n,
  input  logic [PTR_WIDTH-1:0] gray_in,
  output logic [PTR_WIDTH-1:0] gray_out,
  output logic [PTR_WIDTH-1:0] bin_out
);

  logic [PTR_WIDTH-1:0] meta_q;

  // Two flops in the destination domain. Only one bit of a Gray
  // pointer moves per step, so a late sample is off by one at most.
  always_ff @(posedge dst_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      meta_q   <= '0;
      gray_out <= '0;
    end else begin
      meta_q   <= gray_in;
      gray_out <= meta_q;
    end
  end

  // Each binary bit is the XOR of all Gray bits at and above it.
  always_comb begin
    for (int i = 0; i < PTR_WIDTH; i++) begin
      bin_out[i] = ^(gray_out >> i);
    end
  end

endmodule

/* src/dualport_ram.sv */
`timescale 1ns/10ps
`include "cdc_burst_macros.svh"

module dualport_ram (
  input  logic      wr_clk,
  input  logic      rd_clk,
  ram_port_if.mem   port
);

  cdc_burst_pkg::data_t mem [0:`CDC_FIFO_DEPTH-1];

  // Write side, clocked by the producer.
  always_ff @(posedge wr_clk) begin
    if (port.wr_en) begin
      mem[port.wr_addr] <= port.wr_data;
    end
  end

  // Read side. The word is valid one rd_clk cycle after rd_en and
  // holds until the next read.
  always_ff @(posedge rd_clk) begin
    if (port.rd_en) begin
      port.rd_data <= mem[port.rd_addr];
    end
  end

endmodule

/* src/cdc_burst_if.sv */
`timescale 1ns/10ps
`include "cdc_burst_macros.svh"

// --------------------------------------------------
// Memory port between the FIFO control and the RAM.
// --------------------------------------------------
interface ram_port_if;

  logic                        wr_en;
  logic [`CDC_ADDR_WIDTH-1:0]  wr_addr;
  cdc_burst_pkg::data_t        wr_data;
  logic                        rd_en;
  logic [`CDC_ADDR_WIDTH-1:0]  rd_addr;
  cdc_burst_pkg::data_t        rd_data;

  modport ctrl (
    output wr_en,
    output wr_addr,
    output wr_data,
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

// --------------------------------------------------
// Read port of the FIFO as seen by the burst reader.
// --------------------------------------------------
interface fifo_rd_if;

  logic                  rd_en;
  cdc_burst_pkg::data_t  rd_data;
  logic                  empty;
  cdc_burst_pkg::ptr_t   rd_level;

  modport reader (output rd_en, input rd_data, input empty, input rd_level);

  modport fifo (input rd_en, output rd_data, output empty, output rd_level);

endinterface

/* src/cdc_burst_pkg.sv */
`include "cdc_burst_macros.svh"

package cdc_burst_pkg;

  // One data word.
  typedef logic [`CDC_DATA_WIDTH-1:0] data_t;

  // Pointer or fill level, with one extra wrap bit above the address.
  typedef logic [`CDC_ADDR_WIDTH:0] ptr_t;

  // Burst reader states.
  typedef enum logic [1:0] {
    RD_IDLE  = 2'd0,
    RD_BURST = 2'd1,
    RD_DRAIN = 2'd2
  } rd_state_e;

endpackage

/* src/cdc_burst_macros.svh */
`ifndef CDC_BURST_MACROS_SVH
`define CDC_BURST_MACROS_SVH

// Word width of the data path.
`define CDC_DATA_WIDTH 8

// FIFO geometry. The address width is the base-two log of the depth.
`define CDC_FIFO_DEPTH 16
`define CDC_ADDR_WIDTH 4

// Write-side fill level at which afull is raised.
`define CDC_AFULL_LEVEL 12

// Words per full output burst.
`define CDC_BURST_LEN 4

// Cycles a partial burst waits in rd_clk before it is drained.
`define CDC_DRAIN_TIMEOUT 16

`endif
